//--- design/bus_request_port.sv
// Starts one access per rising edge of i_request; the master must drop i_request after o_ready
`timescale 1ns/1ps

module bus_request_port (
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_request,
	input  logic                           i_rw,
	input  logic [mem_bus_pkg::ADDR_W-1:0] i_address,
	input  mem_bus_pkg::bus_word_t         i_wdata,
	output mem_bus_pkg::bus_word_t         o_rdata,
	output logic                           o_ready,
	word_req_if.master                     word
);

	import mem_bus_pkg::*;

	enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_GAP
	} state;

	logic request_q;	// i_request one cycle back
	logic new_request;

	logic [ADDR_W-1:0] address_q;
	logic              rw_q;
	bus_word_t         wdata_q;

	// A request still high from the last access is not a new one
	assign new_request = i_request && !request_q;

	//////////////////////////////////////////////////
	// Control

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state <= ST_IDLE;
			request_q <= 1'b0;
			word.request <= 1'b0;
		end else begin
			request_q <= i_request;
			case (state)
				ST_IDLE: begin
					if (new_request) begin
						word.request <= 1'b1;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (word.ready) begin
						word.request <= 1'b0;
						state <= ST_GAP;
					end
				end
				default: state <= ST_IDLE;	// Idle cycle lets the bridge reset
			endcase
		end
	end

	// Request fields, held for the whole access
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && new_request) begin
			address_q <= i_address;
			rw_q <= i_rw;
			wdata_q <= i_wdata;
		end
	end

	assign word.address = address_q;
	assign word.rw = rw_q;
	assign word.wdata = wdata_q;

	// Bridge ready lingers into the gap, so only pass it while busy
	assign o_ready = (state == ST_BUSY) && word.ready;
	assign o_rdata = word.rdata;

endmodule

//--- design/half_ram_if.sv
// Halfword RAM channel with level handshake; address counts halfwords, not bytes
`timescale 1ns/1ps

interface half_ram_if;

	import ram_dev_pkg::*;

	logic                  request;
	logic                  rw;	// 1 = write
	logic [RAM_ADDR_W-1:0] address;
	half_t                 wdata;
	half_t                 rdata;	// Valid with ready on reads
	logic                  ready;

	// Bridge side
	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	// RAM side
	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

//--- design/mem_16_to_32.sv
// Word to halfword bridge, low half first; uses byte address bits 18:2 only
`timescale 1ns/1ps

module mem_16_to_32 (
	input logic        i_clock,
	input logic        i_reset,
	word_req_if.slave  word,
	half_ram_if.master ram
);

	import mem_bus_pkg::*;
	import ram_dev_pkg::*;

	enum logic [2:0] {
		ST_LO_START,
		ST_LO_WAIT,
		ST_HI_START,
		ST_HI_WAIT,
		ST_DONE
	} state;

	logic [RAM_ADDR_W-2:0] word_index;	// Word number inside the RAM
	logic [RAM_ADDR_W-1:0] ram_address_q;
	half_t                 ram_wdata_q;
	bus_word_t             rdata_q;	// Halves gathered here

	// Byte address to word number, low two bits dropped
	assign word_index = word.address[RAM_ADDR_W:2];

	assign ram.rw = word.rw;	// Held stable by the bus port
	assign ram.address = ram_address_q;
	assign ram.wdata = ram_wdata_q;
	assign word.rdata = rdata_q;

	//////////////////////////////////////////////////
	// Bridge FSM

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state <= ST_LO_START;
			ram.request <= 1'b0;
			word.ready <= 1'b0;
		end else if (!word.request) begin
			// Back to the start whenever the word request is gone
			state <= ST_LO_START;
			ram.request <= 1'b0;
			word.ready <= 1'b0;
		end else begin
			case (state)
				ST_LO_START: begin
					ram.request <= 1'b1;
					state <= ST_LO_WAIT;
				end
				ST_LO_WAIT: begin
					if (ram.ready) begin
						ram.request <= 1'b0;
						state <= ST_HI_START;
					end
				end
				ST_HI_START: begin
					// RAM ready from the low half is still up here, ignore it
					ram.request <= 1'b1;
					state <= ST_HI_WAIT;
				end
				ST_HI_WAIT: begin
					if (ram.ready) begin
						ram.request <= 1'b0;
						word.ready <= 1'b1;
						state <= ST_DONE;
					end
				end
				default: begin
					state <= ST_DONE;	// Hold ready until request drops
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Halfword address and data

	always_ff @(posedge i_clock) begin
		if (word.request) begin
			case (state)
				ST_LO_START: begin
					ram_address_q <= {word_index, 1'b0};
					ram_wdata_q <= word.wdata.half.lo;
				end
				ST_LO_WAIT: begin
					if (ram.ready && !word.rw) begin
						rdata_q.half.lo <= ram.rdata;
					end
				end
				ST_HI_START: begin
					ram_address_q <= {word_index, 1'b1};	// Odd halfword
					ram_wdata_q <= word.wdata.half.hi;
				end
				ST_HI_WAIT: begin
					if (ram.ready && !word.rw) begin
						rdata_q.half.hi <= ram.rdata;
					end
				end
			endcase
		end
	end

endmodule

//--- design/mem_bus_pkg.sv
// Bus side widths and data word; lo half sits in bits 15:0, byte lanes are not split further
package mem_bus_pkg;

	//////////////////////////////////////////////////
	// Widths

	localparam int ADDR_W = 32;	// Byte address
	localparam int DATA_W = 32;
	localparam int HALF_W = DATA_W / 2;

	//////////////////////////////////////////////////
	// Data word

	// Whole word on the bus, two halfwords on the RAM side
	typedef union packed {
		logic [DATA_W-1:0] word;
		struct packed {
			logic [HALF_W-1:0] hi;
			logic [HALF_W-1:0] lo;
		} half;
	} bus_word_t;

endpackage

//--- design/mem_subsys_top.sv
// 32-bit bus onto 16-bit RAM; one word at a time, byte address bits 1:0 and 31:19 ignored
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic                           i_clock,
	input  logic                           i_reset,
	input  logic                           i_request,
	input  logic                           i_rw,
	input  logic [mem_bus_pkg::ADDR_W-1:0] i_address,
	input  mem_bus_pkg::bus_word_t         i_wdata,
	output mem_bus_pkg::bus_word_t         o_rdata,
	output logic                           o_ready
);

	//////////////////////////////////////////////////
	// Internal channels

	word_req_if word_bus ();	// Bus port to bridge
	half_ram_if ram_bus ();	// Bridge to RAM

	//////////////////////////////////////////////////
	// Blocks

	// Holds the external request stable
	bus_request_port bus_port_i (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_request (i_request),
		.i_rw      (i_rw),
		.i_address (i_address),
		.i_wdata   (i_wdata),
		.o_rdata   (o_rdata),
		.o_ready   (o_ready),
		.word      (word_bus.master)
	);

	mem_16_to_32 bridge_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.word    (word_bus.slave),
		.ram     (ram_bus.master)
	);

	sram_16 sram_i (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.ram     (ram_bus.slave)
	);

endmodule

//--- design/ram_dev_pkg.sv
// Halfword RAM device constants; RAM_WAIT must be at least 1
package ram_dev_pkg;

	//////////////////////////////////////////////////
	// Geometry

	localparam int RAM_ADDR_W = 18;	// Halfword address
	localparam int RAM_DEPTH = 1 << RAM_ADDR_W;

	typedef logic [15:0] half_t;

	//////////////////////////////////////////////////
	// Timing

	// Cycles from the first sampled request to ready
	localparam int RAM_WAIT = 2;
	localparam int WAIT_CNT_W = $clog2(RAM_WAIT + 1);

endpackage

//--- design/sram_16.sv
// Behavioral halfword RAM with fixed wait states; contents are undefined until written
`timescale 1ns/1ps

module sram_16 (
	input logic       i_clock,
	input logic       i_reset,
	half_ram_if.slave ram
);

	import ram_dev_pkg::*;

	half_t mem [RAM_DEPTH];

	logic [WAIT_CNT_W-1:0] wait_cnt;
	logic                  ready_q;
	half_t                 rdata_q;
	logic                  access;

	// Wait has run out, serve the access on this edge
	assign access = ram.request && !ready_q && (wait_cnt == WAIT_CNT_W'(RAM_WAIT));

	assign ram.ready = ready_q;
	assign ram.rdata = rdata_q;

	//////////////////////////////////////////////////
	// Wait counter and ready

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			wait_cnt <= '0;
			ready_q <= 1'b0;
		end else if (!ram.request) begin
			wait_cnt <= '0;
			ready_q <= 1'b0;
		end else if (access) begin
			ready_q <= 1'b1;	// Held until request falls
		end else if (!ready_q) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Array and read data
	always_ff @(posedge i_clock) begin
		if (access) begin
			if (ram.rw) begin
				mem[ram.address] <= ram.wdata;
			end else begin
				rdata_q <= mem[ram.address];
			end
		end
	end

endmodule

//--- design/word_req_if.sv
// Word request channel with level handshake; one access in flight, no byte enables
`timescale 1ns/1ps

interface word_req_if;

	import mem_bus_pkg::*;

	logic              request;	// Held until ready
	logic              rw;	// 1 = write
	logic [ADDR_W-1:0] address;
	bus_word_t         wdata;
	bus_word_t         rdata;
	logic              ready;	// Stays up while request is high

	// Bus port side
	modport master (
		output request,
		output rw,
		output address,
		output wdata,
		input  rdata,
		input  ready
	);

	// Bridge side
	modport slave (
		input  request,
		input  rw,
		input  address,
		input  wdata,
		output rdata,
		output ready
	);

endinterface

//--- dv/tb_clock_gen.sv
// Free running clock from time zero; reset is high at start and drops on a rising edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 16
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	initial begin
		o_reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;	// Released on an edge
	end

endmodule

//--- dv/tb_mem_subsys.sv
// Accesses stay inside a 16 word window except the round trip; every read hits a written word
`timescale 1ns/1ps

module tb_mem_subsys;

	import mem_bus_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_OPS = 200;
	localparam int DIRECTED_OPS = 96;	// Bound on the directed part
	localparam int OP_BOUND = 4 * (ram_dev_pkg::RAM_WAIT + 3);
	localparam int TIMEOUT_CYCLES = (DIRECTED_OPS + RANDOM_OPS) * OP_BOUND + RESET_CYCLES + 200;
	localparam logic [31:0] SEED = 32'hd1ab_f3af;
	localparam int WINDOW_WORDS = 16;
	localparam logic [ADDR_W-1:0] WINDOW_BASE = 32'h0000_1000;

	logic              clock;
	logic              reset;
	logic              request;
	logic              rw;
	logic [ADDR_W-1:0] address;
	bus_word_t         wdata;
	bus_word_t         rdata;
	logic              ready;

	bus_word_t   model [WINDOW_WORDS];	// Last value written per word
	logic [31:0] rand_state;
	int          error_count = 0;
	int          ready_rises = 0;
	logic        ready_prev = 1'b0;

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.o_clock (clock),
		.o_reset (reset)
	);

	mem_subsys_top dut_i (
		.i_clock   (clock),
		.i_reset   (reset),
		.i_request (request),
		.i_rw      (rw),
		.i_address (address),
		.i_wdata   (wdata),
		.o_rdata   (rdata),
		.o_ready   (ready)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [ADDR_W-1:0] window_address(input int index, input int offset);
		return WINDOW_BASE + ADDR_W'(index * 4 + offset);
	endfunction

	// -1 outside the window
	function automatic int window_index(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] offset;
		offset = addr - WINDOW_BASE;
		if (offset < ADDR_W'(WINDOW_WORDS * 4)) begin
			return int'(offset >> 2);
		end
		return -1;
	endfunction

	//////////////////////////////////////////////////
	// Handshake checks

	always @(negedge clock) begin
		if (ready && !ready_prev) begin
			ready_rises++;
		end
		ready_prev = ready;
	end

	assert property (@(posedge clock) disable iff (reset) ready |-> request)
		else begin
			error_count++;
			$display("error %0t: o_ready high while i_request is low", $time);
		end

	assert property (@(posedge clock) disable iff (reset) $fell(request) |-> !ready)
		else begin
			error_count++;
			$display("error %0t: o_ready high in the cycle after i_request fell", $time);
		end

	//////////////////////////////////////////////////
	// Bus master tasks

	task automatic run_access(input logic op_rw, input logic [ADDR_W-1:0] op_address,
			input bus_word_t op_wdata, input int hold, output bus_word_t op_rdata);
		int rises_before;
		@(posedge clock);
		rises_before = ready_rises;
		request <= 1'b1;
		rw <= op_rw;
		address <= op_address;
		wdata <= op_wdata;
		@(negedge clock);
		while (!ready) begin
			@(negedge clock);
		end
		op_rdata = rdata;
		repeat (hold) @(posedge clock);	// Master slow to drop request
		@(posedge clock);
		request <= 1'b0;
		@(posedge clock);
		assert (ready_rises == rises_before + 1) else begin
			error_count++;
			$display("error %0t: %0d ready pulses for the access at %h", $time,
				ready_rises - rises_before, op_address);
		end
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input bus_word_t data, input int hold);
		bus_word_t unused;
		int slot;
		run_access(1'b1, addr, data, hold, unused);
		slot = window_index(addr);
		if (slot >= 0) begin
			model[slot] = data;
		end
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input bus_word_t expected, input int hold);
		bus_word_t got;
		run_access(1'b0, addr, '0, hold, got);
		assert (got === expected) else begin
			error_count++;
			$display("error %0t: read at %h returned %h, expected %h", $time, addr, got, expected);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic [31:0] r;
		int          index;
		int          offset;
		int          hold;
		request <= 1'b0;
		rw <= 1'b0;
		address <= '0;
		wdata <= '0;
		rand_state = SEED;

		@(posedge clock);
		@(negedge clock);
		while (reset) begin
			assert (!ready) else begin
				error_count++;
				$display("error %0t: o_ready high during reset", $time);
			end
			@(negedge clock);
		end
		assert (!ready) else begin
			error_count++;
			$display("error %0t: o_ready high in the first cycle after reset", $time);
		end

		// Round trip outside the window, distinct halves
		write_word(32'h0002_0000, 32'ha5c3_0f96, 0);
		read_check(32'h0002_0000, 32'ha5c3_0f96, 0);
		write_word(32'h0002_0004, 32'h1234_abcd, 0);
		read_check(32'h0002_0004, 32'h1234_abcd, 0);

		// Neighbouring words, then odd words rewritten
		for (index = 0; index < WINDOW_WORDS; index++) begin
			rand_state = lcg_next(rand_state);
			write_word(window_address(index, 0), rand_state, 0);
		end
		for (index = 1; index < WINDOW_WORDS; index += 2) begin
			write_word(window_address(index, 0), ~model[index], 0);
		end
		for (index = 0; index < WINDOW_WORDS; index++) begin
			read_check(window_address(index, 0), model[index], 0);
		end

		// Low address bits select nothing
		write_word(window_address(5, 1), 32'hcafe_0001, 0);
		for (offset = 0; offset < 4; offset++) begin
			read_check(window_address(5, offset), model[5], 0);
		end
		write_word(window_address(9, 3), 32'h0bad_f00d, 0);
		read_check(window_address(9, 0), model[9], 0);
		read_check(window_address(8, 2), model[8], 0);

		// Master keeps request up after ready
		write_word(window_address(2, 0), 32'h5555_aaaa, 2);
		read_check(window_address(2, 2), model[2], 3);

		repeat (RANDOM_OPS) begin
			rand_state = lcg_next(rand_state);
			r = rand_state;
			index = int'(r[19:16]) % WINDOW_WORDS;
			offset = int'(r[21:20]);
			hold = (r[23:22] == 2'b11) ? 1 : 0;
			rand_state = lcg_next(rand_state);
			if (r[31]) begin
				write_word(window_address(index, offset), rand_state, hold);
			end else begin
				read_check(window_address(index, offset), model[index], hold);
			end
		end

		$display("Finished with %0d errors", error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Run timed out after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- files.f
design/mem_bus_pkg.sv
design/ram_dev_pkg.sv
design/word_req_if.sv
design/half_ram_if.sv
design/bus_request_port.sv
design/mem_16_to_32.sv
design/sram_16.sv
design/mem_subsys_top.sv
dv/tb_clock_gen.sv
dv/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --top-module tb_mem_subsys -f files.f -o sim_mem_subsys; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_mem_subsys)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q 'All tests passed!'; then
	exit 0
fi
exit 1
